//--- design/eth_mac_1g_rgmii.sv
/* Gigabit Ethernet MAC top with RGMII pins and receive clock speed detection.
   Ties the PHY interface to the transmit and receive halves over one GMII bus. */

`timescale 1ns/1ps

module eth_mac_1g_rgmii #(
    parameter bit enable_padding   = 1'b1,
    parameter int min_frame_length = 64
) (
    input  logic       gtx_clk,
    input  logic       gtx_rst,

    // Transmit stream
    input  logic [7:0] tx_axis_tdata,
    input  logic       tx_axis_tvalid,
    output logic       tx_axis_tready,
    input  logic       tx_axis_tlast,
    input  logic       tx_axis_tuser,

    // Receive stream
    output logic [7:0] rx_axis_tdata,
    output logic       rx_axis_tvalid,
    output logic       rx_axis_tlast,
    output logic       rx_axis_tuser,

    // RGMII pins
    input  logic       rgmii_rx_clk,
    input  logic [3:0] rgmii_rxd,
    input  logic       rgmii_rx_ctl,
    output logic       rgmii_tx_clk,
    output logic [3:0] rgmii_txd,
    output logic       rgmii_tx_ctl,

    // Status and configuration
    output logic       tx_error_underflow,
    output logic       rx_error_bad_frame,
    output logic       rx_error_bad_fcs,
    output logic [1:0] speed,
    input  logic [7:0] ifg_delay
);

    gmii_if gmii ();

    logic [2:0]      rx_prescale;
    logic [2:0]      prescale_sync;
    logic [6:0]      ref_cnt;
    logic [1:0]      edge_cnt;
    eth_pkg::speed_t speed_reg;

    // Free running divide by 8 of the receive clock
    always_ff @(posedge rgmii_rx_clk) begin
        if (gtx_rst) begin
            rx_prescale <= '0;
        end else begin
            rx_prescale <= rx_prescale + 3'd1;
        end
    end

    // Prescaler MSB into gtx_clk
    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            prescale_sync <= '0;
        end else begin
            prescale_sync <= {prescale_sync[1:0], rx_prescale[2]};
        end
    end

    // Race the reference count against prescaled edges
    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            ref_cnt   <= '0;
            edge_cnt  <= '0;
            speed_reg <= eth_pkg::speed_1000;
        end else begin
            ref_cnt <= ref_cnt + 7'd1;
            if (prescale_sync[2] ^ prescale_sync[1]) begin
                edge_cnt <= edge_cnt + 2'd1;
            end
            // Window ran out before enough edges, slow link
            if (&ref_cnt) begin
                ref_cnt   <= '0;
                edge_cnt  <= '0;
                speed_reg <= eth_pkg::speed_10;
            end
            // Enough edges seen, decide from the elapsed reference count
            if (&edge_cnt) begin
                ref_cnt  <= '0;
                edge_cnt <= '0;
                if (ref_cnt[6:5] != 2'b00) begin
                    speed_reg <= eth_pkg::speed_100;
                end else begin
                    speed_reg <= eth_pkg::speed_1000;
                end
            end
        end
    end

    assign speed = speed_reg;

    rgmii_phy_if i_rgmii_phy_if (
        .gtx_clk      (gtx_clk),
        .gtx_rst      (gtx_rst),
        .gmii         (gmii.phy),
        .rgmii_rx_clk (rgmii_rx_clk),
        .rgmii_rxd    (rgmii_rxd),
        .rgmii_rx_ctl (rgmii_rx_ctl),
        .rgmii_tx_clk (rgmii_tx_clk),
        .rgmii_txd    (rgmii_txd),
        .rgmii_tx_ctl (rgmii_tx_ctl)
    );

    eth_mac_1g_tx #(
        .enable_padding   (enable_padding),
        .min_frame_length (min_frame_length)
    ) i_eth_mac_1g_tx (
        .gtx_clk            (gtx_clk),
        .gtx_rst            (gtx_rst),
        .tx_axis_tdata      (tx_axis_tdata),
        .tx_axis_tvalid     (tx_axis_tvalid),
        .tx_axis_tready     (tx_axis_tready),
        .tx_axis_tlast      (tx_axis_tlast),
        .tx_axis_tuser      (tx_axis_tuser),
        .ifg_delay          (ifg_delay),
        .gmii               (gmii.mac),
        .tx_error_underflow (tx_error_underflow)
    );

    eth_mac_1g_rx i_eth_mac_1g_rx (
        .gtx_clk            (gtx_clk),
        .gtx_rst            (gtx_rst),
        .gmii               (gmii.rx_mac),
        .rx_axis_tdata      (rx_axis_tdata),
        .rx_axis_tvalid     (rx_axis_tvalid),
        .rx_axis_tlast      (rx_axis_tlast),
        .rx_axis_tuser      (rx_axis_tuser),
        .rx_error_bad_frame (rx_error_bad_frame),
        .rx_error_bad_fcs   (rx_error_bad_fcs)
    );

endmodule

//--- design/eth_mac_1g_rx.sv
/* Receive deframer: strips preamble and FCS from the GMII bus, checks the CRC.
   Payload leaves on a stream without back-pressure, errors marked with tlast. */

`timescale 1ns/1ps

module eth_mac_1g_rx (
    input  logic       gtx_clk,
    input  logic       gtx_rst,
    gmii_if.rx_mac     gmii,
    output logic [7:0] rx_axis_tdata,
    output logic       rx_axis_tvalid,
    output logic       rx_axis_tlast,
    output logic       rx_axis_tuser,
    output logic       rx_error_bad_frame,
    output logic       rx_error_bad_fcs
);

    logic        in_frame;
    logic [2:0]  fill_cnt;
    logic        out_valid;
    logic        err_seen;
    logic [31:0] crc_reg;
    logic [7:0]  out_data;
    logic        frame_end;

    // Delay line deep enough to hold back the FCS
    logic [7:0]  dly [eth_pkg::fcs_len];

    // Control, delimiter hunt and fill level
    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            in_frame  <= 1'b0;
            fill_cnt  <= '0;
            out_valid <= 1'b0;
            err_seen  <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            if (!in_frame) begin
                // Preamble bytes are skipped until the SFD
                if (gmii.rx_dv && (gmii.rxd == eth_pkg::sfd_byte)) begin
                    in_frame <= 1'b1;
                    fill_cnt <= '0;
                    err_seen <= 1'b0;
                end
            end else if (gmii.rx_dv) begin
                // Oldest byte leaves only once the line is full
                if (fill_cnt == 3'(eth_pkg::fcs_len)) begin
                    out_valid <= 1'b1;
                end else begin
                    fill_cnt <= fill_cnt + 3'd1;
                end
                if (gmii.rx_er) begin
                    err_seen <= 1'b1;
                end
            end else begin
                in_frame <= 1'b0;
            end
        end
    end

    // Data path, CRC over every byte after the SFD, FCS included
    always_ff @(posedge gtx_clk) begin
        if (!in_frame) begin
            crc_reg <= eth_pkg::crc_init;
        end else if (gmii.rx_dv) begin
            crc_reg  <= eth_pkg::crc32_next(crc_reg, gmii.rxd);
            out_data <= dly[eth_pkg::fcs_len - 1];
            dly[0]   <= gmii.rxd;
            for (int i = 1; i < eth_pkg::fcs_len; i++) begin
                dly[i] <= dly[i - 1];
            end
        end
    end

    // rx_dv dropping means the byte now on the output was the last payload byte
    assign frame_end = out_valid & ~gmii.rx_dv;

    assign rx_axis_tdata  = out_data;
    assign rx_axis_tvalid = out_valid;
    assign rx_axis_tlast  = frame_end;

    // Error status only qualified at the end of a frame
    assign rx_error_bad_fcs   = frame_end & (crc_reg != eth_pkg::crc_residue);
    assign rx_error_bad_frame = frame_end & err_seen;
    assign rx_axis_tuser      = rx_error_bad_fcs | rx_error_bad_frame;

endmodule

//--- design/eth_mac_1g_tx.sv
/* Transmit framer: stream bytes in, GMII frame out with preamble, pad and FCS.
   Enforces the inter-frame gap and flags source underflow mid-frame. */

`timescale 1ns/1ps

module eth_mac_1g_tx #(
    parameter bit enable_padding   = 1'b1,
    parameter int min_frame_length = 64
) (
    input  logic       gtx_clk,
    input  logic       gtx_rst,
    input  logic [7:0] tx_axis_tdata,
    input  logic       tx_axis_tvalid,
    output logic       tx_axis_tready,
    input  logic       tx_axis_tlast,
    input  logic       tx_axis_tuser,
    input  logic [7:0] ifg_delay,
    gmii_if.mac        gmii,
    output logic       tx_error_underflow
);

    // Payload plus pad before the FCS
    localparam logic [15:0] min_data_len = 16'(min_frame_length - eth_pkg::fcs_len);

    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_payload,
        st_pad,
        st_fcs,
        st_gap
    } state_t;

    state_t      state;
    logic [2:0]  cnt;
    logic [15:0] byte_cnt;
    logic [7:0]  ifg_cnt;
    logic [31:0] crc_reg;
    logic        drop;

    // Source is only accepted in the payload state
    assign tx_axis_tready = (state == st_payload);

    // Each state produces the byte for the next cycle
    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            state              <= st_idle;
            cnt                <= '0;
            byte_cnt           <= '0;
            ifg_cnt            <= '0;
            drop               <= 1'b0;
            gmii.tx_en         <= 1'b0;
            gmii.tx_er         <= 1'b0;
            tx_error_underflow <= 1'b0;
        end else begin
            tx_error_underflow <= 1'b0;
            gmii.tx_er         <= 1'b0;
            case (state)
                st_idle: begin
                    gmii.tx_en <= 1'b0;
                    // First preamble byte goes out with the state change
                    if (tx_axis_tvalid) begin
                        gmii.txd   <= eth_pkg::preamble_byte;
                        gmii.tx_en <= 1'b1;
                        cnt        <= 3'd1;
                        byte_cnt   <= '0;
                        crc_reg    <= eth_pkg::crc_init;
                        state      <= st_preamble;
                    end
                end
                st_preamble: begin
                    if (cnt == 3'(eth_pkg::preamble_len)) begin
                        gmii.txd <= eth_pkg::sfd_byte;
                        state    <= st_payload;
                    end else begin
                        gmii.txd <= eth_pkg::preamble_byte;
                        cnt      <= cnt + 3'd1;
                    end
                end
                st_payload: begin
                    if (drop) begin
                        // Discard the rest of an underflowed frame
                        gmii.tx_en <= 1'b0;
                        if (tx_axis_tvalid && tx_axis_tlast) begin
                            drop    <= 1'b0;
                            ifg_cnt <= ifg_delay;
                            state   <= st_gap;
                        end
                    end else if (!tx_axis_tvalid) begin
                        // Source ran dry, close the frame with an error byte
                        gmii.txd           <= 8'h00;
                        gmii.tx_er         <= 1'b1;
                        tx_error_underflow <= 1'b1;
                        drop               <= 1'b1;
                    end else begin
                        gmii.txd   <= tx_axis_tdata;
                        gmii.tx_er <= tx_axis_tlast & tx_axis_tuser;
                        crc_reg    <= eth_pkg::crc32_next(crc_reg, tx_axis_tdata);
                        byte_cnt   <= byte_cnt + 16'd1;
                        if (tx_axis_tlast) begin
                            cnt <= '0;
                            if (enable_padding && (byte_cnt + 16'd1 < min_data_len)) begin
                                state <= st_pad;
                            end else begin
                                state <= st_fcs;
                            end
                        end
                    end
                end
                st_pad: begin
                    gmii.txd <= 8'h00;
                    crc_reg  <= eth_pkg::crc32_next(crc_reg, 8'h00);
                    byte_cnt <= byte_cnt + 16'd1;
                    if (byte_cnt + 16'd1 >= min_data_len) begin
                        state <= st_fcs;
                    end
                end
                st_fcs: begin
                    // Complemented CRC, least significant byte first
                    gmii.txd <= ~crc_reg[{cnt[1:0], 3'b000} +: 8];
                    cnt      <= cnt + 3'd1;
                    if (cnt == 3'(eth_pkg::fcs_len - 1)) begin
                        ifg_cnt <= ifg_delay;
                        state   <= st_gap;
                    end
                end
                st_gap: begin
                    gmii.tx_en <= 1'b0;
                    if (ifg_cnt > 8'd1) begin
                        ifg_cnt <= ifg_cnt - 8'd1;
                    end else begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- design/eth_pkg.sv
/* Shared Ethernet constants, link speed codes and the CRC-32 byte update.
   Referenced by scoped name from the MAC halves and the testbench. */

package eth_pkg;

    // Frame delimiting bytes as seen on the GMII bus
    localparam logic [7:0] preamble_byte = 8'h55;
    localparam logic [7:0] sfd_byte      = 8'hd5;

    // Preamble bytes ahead of the SFD
    localparam int preamble_len = 7;

    // FCS length in bytes
    localparam int fcs_len = 4;

    // Reflected form of the 802.3 polynomial 0x04c11db7
    localparam logic [31:0] crc32_poly = 32'hedb88320;

    // CRC register seed at the start of each frame
    localparam logic [31:0] crc_init = 32'hffffffff;

    // Remainder left once a good FCS has been shifted in
    // Register is never complemented on the receive side
    localparam logic [31:0] crc_residue = 32'hdebb20e3;

    // Link speed as reported by the speed detector
    // Code 2'b11 is reserved
    typedef enum logic [1:0] {
        speed_10   = 2'b00,
        speed_100  = 2'b01,
        speed_1000 = 2'b10
    } speed_t;

    // One byte through the CRC-32 register, LSB of the byte first
    function automatic logic [31:0] crc32_next(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            // Feedback is the outgoing bit xor the incoming data bit
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ crc32_poly;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

//--- design/gmii_if.sv
/* Internal GMII byte bus between the MAC halves and the RGMII PHY interface.
   One byte per gtx_clk cycle, no handshake. */

`timescale 1ns/1ps

interface gmii_if;

    // Transmit direction, MAC to PHY
    logic [7:0] txd;
    logic       tx_en;
    logic       tx_er;

    // Receive direction, PHY to MAC
    logic [7:0] rxd;
    logic       rx_dv;
    logic       rx_er;

    // Transmit framer drives the tx side
    modport mac (output txd, tx_en, tx_er);

    // PHY interface consumes tx and produces rx
    modport phy (input txd, tx_en, tx_er, output rxd, rx_dv, rx_er);

    // Receive deframer only reads the rx side
    modport rx_mac (input rxd, rx_dv, rx_er);

endinterface

//--- design/rgmii_phy_if.sv
/* DDR launch and capture between the GMII byte bus and the 4-bit RGMII pins.
   Low nibble travels in the clock-high half, high nibble in the clock-low half. */

`timescale 1ns/1ps

module rgmii_phy_if (
    input  logic       gtx_clk,
    input  logic       gtx_rst,
    gmii_if.phy        gmii,
    input  logic       rgmii_rx_clk,
    input  logic [3:0] rgmii_rxd,
    input  logic       rgmii_rx_ctl,
    output logic       rgmii_tx_clk,
    output logic [3:0] rgmii_txd,
    output logic       rgmii_tx_ctl
);

    // Transmit launch registers
    logic [7:0] tx_d_rise;
    logic [3:0] tx_d_fall;
    logic       tx_ctl_rise;
    logic       tx_er_rise;
    logic       tx_ctl_fall;

    // Receive capture registers
    logic [3:0] rx_d_rise;
    logic       rx_ctl_rise;
    logic [7:0] rx_byte;
    logic       rx_dv_cap;
    logic       rx_er_cap;

    // Whole byte, tx_en and tx_er on the rising edge
    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            tx_ctl_rise <= 1'b0;
            tx_er_rise  <= 1'b0;
        end else begin
            tx_ctl_rise <= gmii.tx_en;
            tx_er_rise  <= gmii.tx_er;
        end
        tx_d_rise <= gmii.txd;
    end

    // High nibble held again for the second half period
    // ctl second half is en xor er per RGMII
    always_ff @(negedge gtx_clk) begin
        if (gtx_rst) begin
            tx_ctl_fall <= 1'b0;
        end else begin
            tx_ctl_fall <= tx_ctl_rise ^ tx_er_rise;
        end
        tx_d_fall <= tx_d_rise[7:4];
    end

    // Output mux stands in for an ODDR cell
    assign rgmii_tx_clk = gtx_clk;
    assign rgmii_txd    = gtx_clk ? tx_d_rise[3:0] : tx_d_fall;
    assign rgmii_tx_ctl = gtx_clk ? tx_ctl_rise : tx_ctl_fall;

    // First half of the RGMII cycle, centred on the falling edge by the skew
    always_ff @(negedge rgmii_rx_clk) begin
        rx_d_rise   <= rgmii_rxd;
        rx_ctl_rise <= rgmii_rx_ctl;
    end

    // Second half joins the first into a byte
    always_ff @(posedge rgmii_rx_clk) begin
        rx_byte   <= {rgmii_rxd, rx_d_rise};
        rx_dv_cap <= rx_ctl_rise;
        rx_er_cap <= rx_ctl_rise ^ rgmii_rx_ctl;
    end

    // Retimed onto gtx_clk, same frequency as the source
    always_ff @(posedge gtx_clk) begin
        if (gtx_rst) begin
            gmii.rx_dv <= 1'b0;
            gmii.rx_er <= 1'b0;
        end else begin
            gmii.rx_dv <= rx_dv_cap;
            gmii.rx_er <= rx_er_cap;
        end
        gmii.rxd <= rx_byte;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile the loopback testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_eth_mac_1g_rgmii -f vlog.f
out=$(./obj_dir/Vtb_eth_mac_1g_rgmii)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1

//--- testbench/eth_mac_1g_rgmii_chk.sv
/* Concurrent protocol checks on the MAC top ports, attached to the DUT with bind. */

`timescale 1ns/1ps

module eth_mac_1g_rgmii_chk (
    input logic       gtx_clk,
    input logic       gtx_rst,
    input logic       tx_axis_tready,
    input logic       rx_axis_tvalid,
    input logic       rx_axis_tlast,
    input logic       tx_error_underflow,
    input logic [1:0] speed
);

    // Source never accepted during reset
    tready_quiet_in_reset: assert property (@(posedge gtx_clk) gtx_rst |-> !tx_axis_tready)
        else $error("tx_axis_tready high while gtx_rst is high");

    // End marker only on a valid byte
    tlast_needs_tvalid: assert property (@(posedge gtx_clk) disable iff (gtx_rst)
        rx_axis_tlast |-> rx_axis_tvalid)
        else $error("rx_axis_tlast without rx_axis_tvalid");

    // Code 11 is reserved
    speed_code_valid: assert property (@(posedge gtx_clk) disable iff (gtx_rst)
        speed != 2'b11)
        else $error("speed holds the reserved code");

    underflow_single_cycle: assert property (@(posedge gtx_clk) disable iff (gtx_rst)
        tx_error_underflow |=> !tx_error_underflow)
        else $error("tx_error_underflow longer than one cycle");

endmodule

//--- testbench/tb_eth_mac_1g_rgmii.sv
/* Loopback testbench for the RGMII MAC, frames leave on the pins and return skewed.
   A reference model predicts each received frame and a monitor compares it. */

`timescale 1ns/1ps

module tb_eth_mac_1g_rgmii;

    typedef logic [7:0] bytes_t[$];

    // Frame kinds, select which receive error flags are expected
    localparam int kind_good      = 0;
    localparam int kind_bad_frame = 1;
    localparam int kind_bad_fcs   = 2;
    localparam int kind_underflow = 3;

    // Payload plus pad ahead of the 4 FCS bytes
    localparam int min_frame_length = 64;
    localparam int min_payload      = min_frame_length - 4;

    // 40 frames of up to 230 cycles, 3 speed windows of up to 2000, margin on top
    localparam int max_cycles = 40 * 230 + 3 * 2000 + 4800;

    logic       gtx_clk;
    logic       gtx_rst;
    logic [7:0] tx_axis_tdata;
    logic       tx_axis_tvalid;
    logic       tx_axis_tready;
    logic       tx_axis_tlast;
    logic       tx_axis_tuser;
    logic [7:0] rx_axis_tdata;
    logic       rx_axis_tvalid;
    logic       rx_axis_tlast;
    logic       rx_axis_tuser;
    logic       rgmii_rx_clk;
    logic [3:0] rgmii_rxd;
    logic       rgmii_rx_ctl;
    logic       rgmii_tx_clk;
    logic [3:0] rgmii_txd;
    logic       rgmii_tx_ctl;
    logic       tx_error_underflow;
    logic       rx_error_bad_frame;
    logic       rx_error_bad_fcs;
    logic [1:0] speed;
    logic [7:0] ifg_delay;

    // Loopback and receive clock divider
    logic [3:0] txd_dly = 4'h0;
    logic       ctl_dly = 1'b0;
    logic [3:0] rxd_flip;
    logic       use_div;
    logic       div_clk = 1'b0;
    int         div_ratio;
    int         div_cnt = 0;
    time        tx_clk_rise = 0;

    // Expected frames, appended by the stimulus side only
    logic [7:0] exp_bytes[$];
    int         exp_len[$];
    int         exp_kind[$];
    bit         exp_known[$];

    // Comparator and bookkeeping
    bytes_t     got_bytes;
    int         frames_done = 0;
    int         byte_base = 0;
    int         err_cmp = 0;
    int         uflow_cnt = 0;
    int         cycle_cnt = 0;
    int         err_main;
    int         test_errs;

    eth_mac_1g_rgmii #(
        .enable_padding   (1'b1),
        .min_frame_length (min_frame_length)
    ) i_eth_mac_1g_rgmii (
        .*
    );

    bind eth_mac_1g_rgmii eth_mac_1g_rgmii_chk i_chk (
        .gtx_clk            (gtx_clk),
        .gtx_rst            (gtx_rst),
        .tx_axis_tready     (tx_axis_tready),
        .rx_axis_tvalid     (rx_axis_tvalid),
        .rx_axis_tlast      (rx_axis_tlast),
        .tx_error_underflow (tx_error_underflow),
        .speed              (speed)
    );

    always #10 gtx_clk = ~gtx_clk;

    // Quarter period of board skew puts each nibble's sample point at its centre
    always @(rgmii_txd or rgmii_tx_ctl) begin
        txd_dly <= #5 rgmii_txd;
        ctl_dly <= #5 rgmii_tx_ctl;
    end

    assign rgmii_rxd    = txd_dly ^ rxd_flip;
    assign rgmii_rx_ctl = ctl_dly;
    assign rgmii_rx_clk = use_div ? div_clk : gtx_clk;

    // Divider counts gtx_clk half periods, so ratio N gives gtx_clk / N
    always @(gtx_clk) begin
        if (div_cnt >= div_ratio - 1) begin
            div_cnt <= 0;
            div_clk <= ~div_clk;
        end else begin
            div_cnt <= div_cnt + 1;
        end
    end

    // Time of the latest transmit clock pin rise
    always @(posedge rgmii_tx_clk) begin
        tx_clk_rise = $time;
    end

    // Run length guard
    always @(posedge gtx_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("Timeout: run went past %0d cycles without finishing", max_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // Expected receive bytes for one sent payload
    // cut >= 0 means the source ran dry before byte cut
    function automatic bytes_t expected_rx(input bytes_t payload, input int cut);
        bytes_t res;
        if (cut >= 0) begin
            // Error byte closes the frame, last 4 bytes stay in the receiver
            for (int i = 0; i < cut - 3; i++) begin
                res.push_back(payload[i]);
            end
        end else begin
            res = payload;
            while (res.size() < min_payload) begin
                res.push_back(8'h00);
            end
        end
        return res;
    endfunction

    function automatic bytes_t random_payload(input int len);
        bytes_t res;
        for (int i = 0; i < len; i++) begin
            res.push_back(8'($urandom));
        end
        return res;
    endfunction

    task automatic expect_frame(input bytes_t payload, input int kind, input int cut,
                                input bit known);
        bytes_t ref_q;
        ref_q = expected_rx(payload, cut);
        foreach (ref_q[i]) begin
            exp_bytes.push_back(ref_q[i]);
        end
        exp_len.push_back(ref_q.size());
        exp_kind.push_back(kind);
        exp_known.push_back(known);
    endtask

    // Drive on the falling edge, a byte moves at the next rising edge if tready
    task automatic send_frame(input bytes_t payload, input bit bad, input int gap_at);
        int  i;
        bit  gap_done;
        i = 0;
        gap_done = 1'b0;
        while (i < payload.size()) begin
            @(negedge gtx_clk);
            if (tx_axis_tready && (i == gap_at) && !gap_done) begin
                // One empty cycle mid payload
                tx_axis_tvalid = 1'b0;
                gap_done = 1'b1;
            end else begin
                tx_axis_tdata  = payload[i];
                tx_axis_tvalid = 1'b1;
                tx_axis_tlast  = (i == payload.size() - 1);
                tx_axis_tuser  = bad && (i == payload.size() - 1);
                if (tx_axis_tready) begin
                    i++;
                end
            end
        end
        @(negedge gtx_clk);
        tx_axis_tvalid = 1'b0;
        tx_axis_tlast  = 1'b0;
        tx_axis_tuser  = 1'b0;
    endtask

    task automatic drain_rx();
        while (frames_done < exp_len.size()) begin
            @(negedge gtx_clk);
        end
        repeat (20) @(negedge gtx_clk);
    endtask

    task automatic wait_speed(input logic [1:0] want, input int limit);
        int n;
        n = 0;
        while ((speed !== want) && (n < limit)) begin
            @(negedge gtx_clk);
            n++;
        end
        if (speed !== want) begin
            $display("CHECK FAILED at %0t: speed expected %b got %b", $time, want, speed);
            err_main++;
        end
    endtask

    task automatic report_test(input int num, input string name);
        int errs;
        errs = err_main + err_cmp - test_errs;
        $display("Test %0d %s finished with %0d errors", num, name, errs);
        test_errs = err_main + err_cmp;
    endtask

    // One received frame against the next expected one
    task automatic check_frame();
        int len;
        int kind;
        bit known;
        bit want_frm;
        bit want_fcs;
        len = exp_len[frames_done];
        kind = exp_kind[frames_done];
        known = exp_known[frames_done];
        want_frm = (kind == kind_bad_frame) || (kind == kind_underflow);
        want_fcs = (kind == kind_bad_fcs);
        if (got_bytes.size() != len) begin
            $display("CHECK FAILED at %0t: rx_axis_tlast position expected %0d got %0d",
                     $time, len, got_bytes.size());
            err_cmp++;
        end else if (known) begin
            for (int i = 0; i < len; i++) begin
                if (got_bytes[i] !== exp_bytes[byte_base + i]) begin
                    $display("CHECK FAILED at %0t: rx_axis_tdata[%0d] expected %02h got %02h",
                             $time, i, exp_bytes[byte_base + i], got_bytes[i]);
                    err_cmp++;
                end
            end
        end
        if (rx_axis_tuser !== (kind != kind_good)) begin
            $display("CHECK FAILED at %0t: rx_axis_tuser expected %0d got %0d",
                     $time, kind != kind_good, rx_axis_tuser);
            err_cmp++;
        end
        if (rx_error_bad_frame !== want_frm) begin
            $display("CHECK FAILED at %0t: rx_error_bad_frame expected %0d got %0d",
                     $time, want_frm, rx_error_bad_frame);
            err_cmp++;
        end
        // Underflow leaves the CRC state undefined
        if ((kind != kind_underflow) && (rx_error_bad_fcs !== want_fcs)) begin
            $display("CHECK FAILED at %0t: rx_error_bad_fcs expected %0d got %0d",
                     $time, want_fcs, rx_error_bad_fcs);
            err_cmp++;
        end
        byte_base += len;
        frames_done++;
    endtask

    // Receive side sampled mid cycle where registered outputs are settled
    always @(negedge gtx_clk) begin
        if (!gtx_rst) begin
            // Transmit clock pin rises with gtx_clk, half a period before this edge
            if ($time - tx_clk_rise != 10) begin
                $display("CHECK FAILED at %0t: rgmii_tx_clk last rise expected %0t got %0t",
                         $time, $time - 10, tx_clk_rise);
                err_cmp++;
            end
            if (tx_error_underflow) begin
                uflow_cnt++;
            end
            if ((rx_error_bad_fcs || rx_error_bad_frame) && !rx_axis_tlast) begin
                $display("Error at %0t: receive error pulse away from a frame end", $time);
                err_cmp++;
            end
            if (rx_axis_tvalid) begin
                if (frames_done >= exp_len.size()) begin
                    $display("Error at %0t: receive byte with no frame expected", $time);
                    err_cmp++;
                end else begin
                    got_bytes.push_back(rx_axis_tdata);
                    if (rx_axis_tlast) begin
                        check_frame();
                        got_bytes.delete();
                    end
                end
            end
        end
    end

    initial begin
        bytes_t payload;
        int     len;
        int     uflow_before;
        void'($urandom(90850));
        err_main       = 0;
        test_errs      = 0;
        gtx_clk        = 1'b0;
        gtx_rst        = 1'b1;
        tx_axis_tdata  = 8'h00;
        tx_axis_tvalid = 1'b0;
        tx_axis_tlast  = 1'b0;
        tx_axis_tuser  = 1'b0;
        ifg_delay      = 8'd12;
        rxd_flip       = 4'h0;
        use_div        = 1'b0;
        div_ratio      = 5;
        repeat (4) @(negedge gtx_clk);
        gtx_rst = 1'b0;

        // Idle link, the monitor flags any stray receive byte
        repeat (200) @(negedge gtx_clk);
        if (speed !== eth_pkg::speed_1000) begin
            $display("CHECK FAILED at %0t: speed expected %b got %b", $time,
                     eth_pkg::speed_1000, speed);
            err_main++;
        end
        if (uflow_cnt != 0) begin
            $display("Error at %0t: underflow pulse on an idle link", $time);
            err_main++;
        end
        report_test(1, "idle after reset");

        payload = random_payload(20);
        expect_frame(payload, kind_good, -1, 1'b1);
        send_frame(payload, 1'b0, -1);
        drain_rx();
        report_test(2, "short frame padded");

        for (int f = 0; f < 30; f++) begin
            len = int'($urandom_range(200, 46));
            payload = random_payload(len);
            expect_frame(payload, kind_good, -1, 1'b1);
            send_frame(payload, 1'b0, -1);
        end
        drain_rx();
        report_test(3, "random frames back to back");

        payload = random_payload(50);
        expect_frame(payload, kind_bad_frame, -1, 1'b1);
        send_frame(payload, 1'b1, -1);
        // Corrupted byte position depends on timing, so only length and flags count
        payload = random_payload(60);
        expect_frame(payload, kind_bad_fcs, -1, 1'b0);
        fork
            send_frame(payload, 1'b0, -1);
            begin
                // Hit the low nibble of a payload byte once this frame is under way
                @(posedge tx_axis_tready);
                repeat (20) @(posedge gtx_clk);
                #5 rxd_flip = 4'b0100;
                #10 rxd_flip = 4'b0000;
            end
        join
        drain_rx();
        report_test(4, "error paths");

        uflow_before = uflow_cnt;
        payload = random_payload(80);
        expect_frame(payload, kind_underflow, 30, 1'b1);
        send_frame(payload, 1'b0, 30);
        payload = random_payload(64);
        expect_frame(payload, kind_good, -1, 1'b1);
        send_frame(payload, 1'b0, -1);
        drain_rx();
        if (uflow_cnt != uflow_before + 1) begin
            $display("CHECK FAILED at %0t: tx_error_underflow pulses expected %0d got %0d",
                     $time, 1, uflow_cnt - uflow_before);
            err_main++;
        end
        report_test(5, "source underflow");

        div_ratio = 5;
        use_div = 1'b1;
        wait_speed(eth_pkg::speed_100, 300);
        div_ratio = 50;
        wait_speed(eth_pkg::speed_10, 2000);
        use_div = 1'b0;
        wait_speed(eth_pkg::speed_1000, 2000);
        report_test(6, "speed detection");

        $display("Summary: %0d frames checked, %0d errors", frames_done, err_main + err_cmp);
        if (err_main + err_cmp == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
design/eth_pkg.sv
design/gmii_if.sv
design/rgmii_phy_if.sv
design/eth_mac_1g_tx.sv
design/eth_mac_1g_rx.sv
design/eth_mac_1g_rgmii.sv
testbench/eth_mac_1g_rgmii_chk.sv
testbench/tb_eth_mac_1g_rgmii.sv
